/* design/fp_mul_settings.svh */
`ifndef FP_MUL_SETTINGS_SVH
`define FP_MUL_SETTINGS_SVH

// Single-precision field widths
`define FP_EXP_W  8
`define FP_FRAC_W 23
`define FP_BIAS   127

// Rounding-mode codes on r_mode
`define FP_RM_RNE 3'b000
`define FP_RM_RTZ 3'b001
`define FP_RM_RDN 3'b010
`define FP_RM_RUP 3'b011
`define FP_RM_RMM 3'b100

// Canonical quiet NaN
`define FP_QNAN 32'h7fc00000

`endif

/* design/fp_mul_pkg.sv */
`include "fp_mul_settings.svh"

package fp_mul_pkg;

    // Full float word, sign + exponent + fraction
    typedef logic [`FP_EXP_W+`FP_FRAC_W:0] fp_word_t;

    // Biased exponent field
    typedef logic [`FP_EXP_W-1:0] exp_t;

    // Stored fraction without hidden bit
    typedef logic [`FP_FRAC_W-1:0] frac_t;

    // Mantissa with hidden bit
    typedef logic [`FP_FRAC_W:0] mant_t;

    // Raw product of two mantissas
    typedef logic [2*`FP_FRAC_W+1:0] prod_t;

    // Normalized mantissa: hidden bit, fraction, guard, round, sticky
    typedef logic [`FP_FRAC_W+3:0] norm_frac_t;

    // Signed exponent sum, two extra bits to see overflow and underflow
    typedef logic signed [`FP_EXP_W+1:0] exp_sum_t;

    // Rounding-mode code
    typedef logic [2:0] r_mode_t;

endpackage

/* design/fp_mul_decode.sv */
`timescale 1ns/1ns
`include "fp_mul_settings.svh"

module fp_mul_decode (
    input  fp_mul_pkg::fp_word_t fp_x,
    input  fp_mul_pkg::fp_word_t fp_y,
    output logic                 sign_z,
    output fp_mul_pkg::exp_t     exp_x,
    output fp_mul_pkg::exp_t     exp_y,
    output fp_mul_pkg::mant_t    mant_x,
    output fp_mul_pkg::mant_t    mant_y,
    output logic                 x_zero,
    output logic                 y_zero,
    output logic                 x_inf,
    output logic                 y_inf,
    output logic                 x_nan,
    output logic                 y_nan
);
    import fp_mul_pkg::*;

    // Position of the sign bit in the word
    localparam int SIGN_BIT = `FP_EXP_W + `FP_FRAC_W;

    frac_t frac_x;
    frac_t frac_y;
    // Exponent all ones, inf or NaN
    logic  x_exp_max;
    logic  y_exp_max;

    // Field split
    assign exp_x  = fp_x[`FP_FRAC_W +: `FP_EXP_W];
    assign exp_y  = fp_y[`FP_FRAC_W +: `FP_EXP_W];
    assign frac_x = fp_x[`FP_FRAC_W-1:0];
    assign frac_y = fp_y[`FP_FRAC_W-1:0];

    // Result sign is independent of the class
    assign sign_z = fp_x[SIGN_BIT] ^ fp_y[SIGN_BIT];

    // Zero exponent means zero or subnormal, both flushed to zero
    assign x_zero = (exp_x == '0);
    assign y_zero = (exp_y == '0);

    assign x_exp_max = (exp_x == '1);
    assign y_exp_max = (exp_y == '1);

    // Fraction tells infinity from NaN
    assign x_inf = x_exp_max & (frac_x == '0);
    assign y_inf = y_exp_max & (frac_y == '0);
    assign x_nan = x_exp_max & (frac_x != '0);
    assign y_nan = y_exp_max & (frac_y != '0);

    // Hidden one restored, flushed operands give a zero mantissa
    assign mant_x = x_zero ? '0 : {1'b1, frac_x};
    assign mant_y = y_zero ? '0 : {1'b1, frac_y};

endmodule

/* design/fp_mul_booth.sv */
`timescale 1ns/1ns
`include "fp_mul_settings.svh"

module fp_mul_booth (
    input  fp_mul_pkg::mant_t mant_a,
    input  fp_mul_pkg::mant_t mant_b,
    output fp_mul_pkg::prod_t product
);
    import fp_mul_pkg::*;

    // Radix-4 digits needed for an unsigned 24-bit multiplier
    localparam int NUM_DIGITS = (`FP_FRAC_W + 3) / 2;
    // Partial product width, holds +-2A as a signed value
    localparam int PP_W = `FP_FRAC_W + 3;
    // Width of the multiplier with zero padding on both ends
    localparam int B_EXT_W = 2 * NUM_DIGITS + 1;

    // Multiplier padded with an implicit zero below bit 0
    // and zeros on top so the last digit is never negative
    logic [B_EXT_W-1:0]     b_ext;
    logic signed [PP_W-1:0] a_one;
    logic signed [PP_W-1:0] a_two;
    logic [2:0]             digit [NUM_DIGITS];
    logic signed [PP_W-1:0] pp    [NUM_DIGITS];
    prod_t                  acc;

    assign b_ext = {2'b00, mant_b, 1'b0};

    // Positive multiples of A
    assign a_one = {2'b00, mant_a};
    assign a_two = {1'b0, mant_a, 1'b0};

    for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_digit
        // Overlapping triple b[2i+1], b[2i], b[2i-1]
        assign digit[i] = b_ext[2*i +: 3];

        // Digit recoding to 0, +-A, +-2A
        always_comb begin
            case (digit[i])
                3'b001,
                3'b010:  pp[i] = a_one;
                3'b011:  pp[i] = a_two;
                3'b100:  pp[i] = -a_two;
                3'b101,
                3'b110:  pp[i] = -a_one;
                default: pp[i] = '0;
            endcase
        end
    end

    // Sum of sign-extended partial products, weighted by 4^i
    // Modulo 2^48 is exact since the true product fits
    always_comb begin
        acc = '0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            acc = acc + (prod_t'({{($bits(prod_t)-PP_W){pp[i][PP_W-1]}}, pp[i]}) << (2*i));
        end
    end

    assign product = acc;

endmodule

/* design/fp_mul_execute.sv */
`timescale 1ns/1ns
`include "fp_mul_settings.svh"

module fp_mul_execute (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  fp_mul_pkg::r_mode_t    r_mode_in,
    input  logic                   sign_z,
    input  fp_mul_pkg::exp_t       exp_x,
    input  fp_mul_pkg::exp_t       exp_y,
    input  fp_mul_pkg::mant_t      mant_x,
    input  fp_mul_pkg::mant_t      mant_y,
    input  logic                   x_zero,
    input  logic                   y_zero,
    input  logic                   x_inf,
    input  logic                   y_inf,
    input  logic                   x_nan,
    input  logic                   y_nan,
    output logic                   exe_valid,
    output logic                   exe_sign,
    output fp_mul_pkg::r_mode_t    exe_r_mode,
    output fp_mul_pkg::exp_sum_t   exe_exp,
    output fp_mul_pkg::norm_frac_t exe_frac,
    output logic                   exe_nan,
    output logic                   exe_inf,
    output logic                   exe_zero
);
    import fp_mul_pkg::*;

    prod_t      frc_z_full;
    prod_t      frc_z_shift;
    norm_frac_t frc_z_norm;
    logic       norm_n;
    exp_sum_t   exp_sum;
    logic       nan_c;
    logic       inf_c;
    logic       zero_c;

    fp_mul_booth booth_i (
        .mant_a  (mant_x),
        .mant_b  (mant_y),
        .product (frc_z_full)
    );

    // Product of two [1,2) mantissas is in [1,4), one shift at most
    assign norm_n      = frc_z_full[47];
    assign frc_z_shift = norm_n ? frc_z_full : {frc_z_full[46:0], 1'b0};

    // Keep 26 bits, dropped low bits fold into sticky
    assign frc_z_norm = {frc_z_shift[47:22], |frc_z_shift[21:0]};

    // Biased sum, one more when the product reached [2,4)
    assign exp_sum = {2'b00, exp_x} + {2'b00, exp_y} - exp_sum_t'(`FP_BIAS)
                     + {{(`FP_EXP_W+1){1'b0}}, norm_n};

    // NaN operand, or infinity times zero
    assign nan_c  = x_nan | y_nan | (x_inf & y_zero) | (y_inf & x_zero);
    assign inf_c  = (x_inf | y_inf) & ~nan_c;
    assign zero_c = (x_zero | y_zero) & ~nan_c;

    // Stage one valid follows start every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= start;
        end
    end

    // Stage one payload, only taken with a new operation
    always_ff @(posedge clk) begin
        if (start) begin
            exe_sign   <= sign_z;
            exe_r_mode <= r_mode_in;
            exe_exp    <= exp_sum;
            exe_frac   <= frc_z_norm;
            exe_nan    <= nan_c;
            exe_inf    <= inf_c;
            exe_zero   <= zero_c;
        end
    end

endmodule

/* design/fp_mul_result.sv */
`timescale 1ns/1ns
`include "fp_mul_settings.svh"

module fp_mul_result (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   exe_valid,
    input  logic                   exe_sign,
    input  fp_mul_pkg::r_mode_t    exe_r_mode,
    input  fp_mul_pkg::exp_sum_t   exe_exp,
    input  fp_mul_pkg::norm_frac_t exe_frac,
    input  logic                   exe_nan,
    input  logic                   exe_inf,
    input  logic                   exe_zero,
    output fp_mul_pkg::fp_word_t   fp_z,
    output logic                   ovrf,
    output logic                   udrf,
    output logic                   zer,
    output logic                   inf,
    output logic                   nan,
    output logic                   done
);
    import fp_mul_pkg::*;

    localparam exp_t EXP_MAX = '1;

    frac_t             frac_base;
    logic              guard_bit;
    logic              round_bit;
    logic              sticky_bit;
    logic              lower_any;
    logic              round_up;
    logic [`FP_FRAC_W:0] frac_inc;
    logic              norm_r;
    frac_t             frac_z;
    exp_sum_t          exp_z;
    fp_word_t          word_c;
    logic              ovrf_c;
    logic              udrf_c;
    logic              zer_c;
    logic              inf_c;
    logic              nan_c;

    // Fraction below the hidden bit, then guard, round and sticky
    assign frac_base  = exe_frac[25:3];
    assign guard_bit  = exe_frac[2];
    assign round_bit  = exe_frac[1];
    assign sticky_bit = exe_frac[0];
    assign lower_any  = guard_bit | round_bit | sticky_bit;

    // Increment decision per mode; directed modes depend on the sign
    always_comb begin
        case (exe_r_mode)
            `FP_RM_RNE: round_up = guard_bit & (round_bit | sticky_bit | frac_base[0]);
            `FP_RM_RDN: round_up = exe_sign & lower_any;
            `FP_RM_RUP: round_up = ~exe_sign & lower_any;
            `FP_RM_RMM: round_up = guard_bit;
            // RTZ and unused codes truncate
            default:    round_up = 1'b0;
        endcase
    end

    assign frac_inc = {1'b0, frac_base} + {{`FP_FRAC_W{1'b0}}, round_up};

    // Carry out leaves the low fraction bits at zero, mantissa is 1.0
    assign norm_r = frac_inc[`FP_FRAC_W];
    assign frac_z = frac_inc[`FP_FRAC_W-1:0];
    assign exp_z  = exe_exp + {{(`FP_EXP_W+1){1'b0}}, norm_r};

    // Exception priority: NaN, inf, zero, overflow, underflow, normal
    always_comb begin
        word_c = {exe_sign, exp_z[`FP_EXP_W-1:0], frac_z};
        ovrf_c = 1'b0;
        udrf_c = 1'b0;
        zer_c  = 1'b0;
        inf_c  = 1'b0;
        nan_c  = 1'b0;
        if (exe_nan) begin
            word_c = `FP_QNAN;
            nan_c  = 1'b1;
        end else if (exe_inf) begin
            word_c = {exe_sign, EXP_MAX, {`FP_FRAC_W{1'b0}}};
            inf_c  = 1'b1;
        end else if (exe_zero) begin
            word_c = {exe_sign, {(`FP_EXP_W+`FP_FRAC_W){1'b0}}};
            zer_c  = 1'b1;
        end else if (exp_z >= exp_sum_t'(EXP_MAX)) begin
            // Overflow saturates to infinity in every mode
            word_c = {exe_sign, EXP_MAX, {`FP_FRAC_W{1'b0}}};
            ovrf_c = 1'b1;
            inf_c  = 1'b1;
        end else if (exp_z <= exp_sum_t'(0)) begin
            // No subnormal results, underflow goes to signed zero
            word_c = {exe_sign, {(`FP_EXP_W+`FP_FRAC_W){1'b0}}};
            udrf_c = 1'b1;
            zer_c  = 1'b1;
        end
    end

    // Stage two, outputs hold until the next done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fp_z <= '0;
            ovrf <= 1'b0;
            udrf <= 1'b0;
            zer  <= 1'b0;
            inf  <= 1'b0;
            nan  <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= exe_valid;
            if (exe_valid) begin
                fp_z <= word_c;
                ovrf <= ovrf_c;
                udrf <= udrf_c;
                zer  <= zer_c;
                inf  <= inf_c;
                nan  <= nan_c;
            end
        end
    end

endmodule

/* design/fp_mul_top.sv */
`timescale 1ns/1ns

module fp_mul_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  fp_mul_pkg::fp_word_t fp_x,
    input  fp_mul_pkg::fp_word_t fp_y,
    input  fp_mul_pkg::r_mode_t  r_mode,
    output fp_mul_pkg::fp_word_t fp_z,
    output logic                 ovrf,
    output logic                 udrf,
    output logic                 zer,
    output logic                 inf,
    output logic                 nan,
    output logic                 done
);
    import fp_mul_pkg::*;

    // Decode outputs, combinational from the operands
    logic       sign_z;
    exp_t       exp_x;
    exp_t       exp_y;
    mant_t      mant_x;
    mant_t      mant_y;
    logic       x_zero;
    logic       y_zero;
    logic       x_inf;
    logic       y_inf;
    logic       x_nan;
    logic       y_nan;

    // Stage one register outputs
    logic       exe_valid;
    logic       exe_sign;
    r_mode_t    exe_r_mode;
    exp_sum_t   exe_exp;
    norm_frac_t exe_frac;
    logic       exe_nan;
    logic       exe_inf;
    logic       exe_zero;

    fp_mul_decode decode_i (
        .fp_x   (fp_x),
        .fp_y   (fp_y),
        .sign_z (sign_z),
        .exp_x  (exp_x),
        .exp_y  (exp_y),
        .mant_x (mant_x),
        .mant_y (mant_y),
        .x_zero (x_zero),
        .y_zero (y_zero),
        .x_inf  (x_inf),
        .y_inf  (y_inf),
        .x_nan  (x_nan),
        .y_nan  (y_nan)
    );

    fp_mul_execute execute_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .r_mode_in  (r_mode),
        .sign_z     (sign_z),
        .exp_x      (exp_x),
        .exp_y      (exp_y),
        .mant_x     (mant_x),
        .mant_y     (mant_y),
        .x_zero     (x_zero),
        .y_zero     (y_zero),
        .x_inf      (x_inf),
        .y_inf      (y_inf),
        .x_nan      (x_nan),
        .y_nan      (y_nan),
        .exe_valid  (exe_valid),
        .exe_sign   (exe_sign),
        .exe_r_mode (exe_r_mode),
        .exe_exp    (exe_exp),
        .exe_frac   (exe_frac),
        .exe_nan    (exe_nan),
        .exe_inf    (exe_inf),
        .exe_zero   (exe_zero)
    );

    fp_mul_result result_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .exe_valid  (exe_valid),
        .exe_sign   (exe_sign),
        .exe_r_mode (exe_r_mode),
        .exe_exp    (exe_exp),
        .exe_frac   (exe_frac),
        .exe_nan    (exe_nan),
        .exe_inf    (exe_inf),
        .exe_zero   (exe_zero),
        .fp_z       (fp_z),
        .ovrf       (ovrf),
        .udrf       (udrf),
        .zer        (zer),
        .inf        (inf),
        .nan        (nan),
        .done       (done)
    );

endmodule

/* sim/fp_mul_properties.sv */
`timescale 1ns/1ns

module fp_mul_properties (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic done,
    input logic ovrf,
    input logic udrf,
    input logic zer,
    input logic inf,
    input logic nan
);

    // Fixed latency of two cycles in both directions
    done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> ##2 done)
        else $error("done missing two cycles after start");

    start_before_done: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(start, 2))
        else $error("done without a start two cycles earlier");

    // Overflow saturates to infinity, underflow to zero
    ovrf_has_inf: assert property (@(posedge clk) disable iff (!rst_n) ovrf |-> inf)
        else $error("ovrf set without inf");

    udrf_has_zer: assert property (@(posedge clk) disable iff (!rst_n) udrf |-> zer)
        else $error("udrf set without zer");

    // At most one result class
    one_class: assert property (@(posedge clk) disable iff (!rst_n) $onehot0({nan, inf, zer}))
        else $error("more than one of nan, inf, zer set");

    done_low_in_reset: assert property (@(posedge clk) !rst_n |-> !done)
        else $error("done high during reset");

endmodule

bind fp_mul_top fp_mul_properties props_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .done  (done),
    .ovrf  (ovrf),
    .udrf  (udrf),
    .zer   (zer),
    .inf   (inf),
    .nan   (nan)
);

/* sim/fp_mul_tb.sv */
`timescale 1ns/1ns
`include "fp_mul_settings.svh"

module fp_mul_tb;

    // Cycles allowed between start and done
    localparam int TIMEOUT_CYCLES = 20;
    localparam int RANDOM_PAIRS   = 200;
    localparam int PIPE_OPS       = 8;

    // Expected flags in the order {ovrf, udrf, zer, inf, nan}
    localparam logic [4:0] FLAGS_NONE = 5'b00000;
    localparam logic [4:0] FLAGS_NAN  = 5'b00001;
    localparam logic [4:0] FLAGS_INF  = 5'b00010;
    localparam logic [4:0] FLAGS_ZER  = 5'b00100;
    localparam logic [4:0] FLAGS_OVF  = 5'b10010;
    localparam logic [4:0] FLAGS_UDF  = 5'b01100;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [31:0] fp_x;
    logic [31:0] fp_y;
    logic [2:0]  r_mode;
    logic [31:0] fp_z;
    logic        ovrf;
    logic        udrf;
    logic        zer;
    logic        inf;
    logic        nan;
    logic        done;

    int          seed = 38094;
    int          checks;
    int          errors;
    // Expected results of operations in flight, oldest first
    logic [36:0] expected_q [$];

    fp_mul_top fp_mul_top_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .fp_x   (fp_x),
        .fp_y   (fp_y),
        .r_mode (r_mode),
        .fp_z   (fp_z),
        .ovrf   (ovrf),
        .udrf   (udrf),
        .zer    (zer),
        .inf    (inf),
        .nan    (nan),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reference result as {flags, word}
    function automatic logic [36:0] model_mul(input logic [31:0] x, input logic [31:0] y,
                                              input logic [2:0] mode);
        logic        sign;
        logic [7:0]  ex;
        logic [7:0]  ey;
        logic        x_z;
        logic        y_z;
        logic        x_i;
        logic        y_i;
        logic        x_n;
        logic        y_n;
        logic [47:0] prod;
        logic [26:0] nfrac;
        logic        lower;
        logic        up;
        logic [23:0] inc;
        int          e;
        sign = x[31] ^ y[31];
        ex   = x[30:23];
        ey   = y[30:23];
        // Zero exponent covers subnormals, flushed to zero
        x_z  = (ex == 8'd0);
        y_z  = (ey == 8'd0);
        x_i  = (ex == 8'hff) && (x[22:0] == 23'd0);
        y_i  = (ey == 8'hff) && (y[22:0] == 23'd0);
        x_n  = (ex == 8'hff) && (x[22:0] != 23'd0);
        y_n  = (ey == 8'hff) && (y[22:0] != 23'd0);
        if (x_n || y_n || (x_i && y_z) || (y_i && x_z)) begin
            return {FLAGS_NAN, `FP_QNAN};
        end
        if (x_i || y_i) begin
            return {FLAGS_INF, sign, 8'hff, 23'd0};
        end
        if (x_z || y_z) begin
            return {FLAGS_ZER, sign, 31'd0};
        end
        // Plain integer product of the mantissas
        prod = {24'd0, 1'b1, x[22:0]} * {24'd0, 1'b1, y[22:0]};
        e = int'(ex) + int'(ey) - `FP_BIAS;
        if (prod[47]) begin
            e = e + 1;
        end else begin
            prod = prod << 1;
        end
        nfrac = {prod[47:22], |prod[21:0]};
        lower = |nfrac[2:0];
        case (mode)
            `FP_RM_RNE: up = nfrac[2] & (nfrac[1] | nfrac[0] | nfrac[3]);
            `FP_RM_RDN: up = sign & lower;
            `FP_RM_RUP: up = ~sign & lower;
            `FP_RM_RMM: up = nfrac[2];
            default:    up = 1'b0;
        endcase
        inc = {1'b0, nfrac[25:3]} + {23'd0, up};
        // Carry out of the fraction bumps the exponent
        if (inc[23]) begin
            e = e + 1;
        end
        if (e >= 255) begin
            return {FLAGS_OVF, sign, 8'hff, 23'd0};
        end
        if (e <= 0) begin
            return {FLAGS_UDF, sign, 31'd0};
        end
        return {FLAGS_NONE, sign, e[7:0], inc[22:0]};
    endfunction

    // Normal operand, exponent kept in 64..191 so most products stay in range
    function automatic logic [31:0] rand_normal();
        logic [31:0] bits;
        logic [7:0]  ex;
        bits = $random(seed);
        ex   = 8'd64 + {1'b0, bits[30:24]};
        return {bits[31], ex, bits[22:0]};
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
        checks++;
        if (exp_val !== act_val) begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp_val, act_val);
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        checks++;
        if (exp_val !== act_val) begin
            errors++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp_val, act_val);
        end
    endtask

    task automatic compare_outputs(input logic [36:0] expected);
        check_word("fp_z", expected[31:0], fp_z);
        check_flag("ovrf", expected[36], ovrf);
        check_flag("udrf", expected[35], udrf);
        check_flag("zer", expected[34], zer);
        check_flag("inf", expected[33], inf);
        check_flag("nan", expected[32], nan);
    endtask

    // Each call consumes at least one fresh falling edge
    task automatic wait_done(output logic ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (done) begin
                ok = 1'b1;
            end
        end
        if (!ok) begin
            errors++;
            $display("Timeout at %0t, done never came within %0d cycles", $time, TIMEOUT_CYCLES);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s finished, %0d errors", name, errors - err_before);
    endtask

    // One operation, then a check that done lasts a single cycle
    task automatic apply_and_check(input logic [31:0] x, input logic [31:0] y,
                                   input logic [2:0] mode, input logic [36:0] expected);
        logic ok;
        @(posedge clk);
        fp_x   <= x;
        fp_y   <= y;
        r_mode <= mode;
        start  <= 1'b1;
        @(posedge clk);
        start  <= 1'b0;
        wait_done(ok);
        if (ok) begin
            compare_outputs(expected);
            @(negedge clk);
            check_flag("done", 1'b0, done);
        end
    endtask

    task automatic check_reset();
        int err_before;
        err_before = errors;
        repeat (4) begin
            @(negedge clk);
            check_flag("done", 1'b0, done);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        // Idle outputs before any start
        repeat (3) begin
            @(negedge clk);
            check_flag("done", 1'b0, done);
            compare_outputs({FLAGS_NONE, 32'h0});
        end
        report_test("reset", err_before);
    endtask

    task automatic run_special();
        int err_before;
        err_before = errors;
        apply_and_check(32'h00000000, 32'h40400000, `FP_RM_RNE, {FLAGS_ZER, 32'h00000000});
        apply_and_check(32'h80000000, 32'h40400000, `FP_RM_RNE, {FLAGS_ZER, 32'h80000000});
        // Subnormal operand is flushed to zero
        apply_and_check(32'h00000001, 32'hc0000000, `FP_RM_RNE, {FLAGS_ZER, 32'h80000000});
        apply_and_check(32'h7f800000, 32'hc0400000, `FP_RM_RNE, {FLAGS_INF, 32'hff800000});
        apply_and_check(32'h7f800000, 32'h00000000, `FP_RM_RNE, {FLAGS_NAN, `FP_QNAN});
        apply_and_check(32'h7fc00001, 32'h3f800000, `FP_RM_RNE, {FLAGS_NAN, `FP_QNAN});
        apply_and_check(32'hff800000, 32'hffa00000, `FP_RM_RUP, {FLAGS_NAN, `FP_QNAN});
        report_test("special operands", err_before);
    endtask

    task automatic run_exact();
        int         err_before;
        logic [2:0] mode;
        err_before = errors;
        mode = `FP_RM_RNE;
        repeat (5) begin
            apply_and_check(32'h40400000, 32'h40400000, mode, {FLAGS_NONE, 32'h41100000});
            apply_and_check(32'hc0400000, 32'h40400000, mode, {FLAGS_NONE, 32'hc1100000});
            apply_and_check(32'hc0400000, 32'hc0400000, mode, {FLAGS_NONE, 32'h41100000});
            mode = mode + 3'd1;
        end
        report_test("exact products", err_before);
    endtask

    task automatic run_rounding_directed();
        int err_before;
        err_before = errors;
        // Product of two 0x3fb504f3 sits just under 2, all fraction bits set
        apply_and_check(32'h3fb504f3, 32'h3fb504f3, `FP_RM_RUP, {FLAGS_NONE, 32'h40000000});
        apply_and_check(32'h3fb504f3, 32'h3fb504f3, `FP_RM_RNE, {FLAGS_NONE, 32'h3fffffff});
        apply_and_check(32'h3fb504f3, 32'h3fb504f3, `FP_RM_RTZ, {FLAGS_NONE, 32'h3fffffff});
        apply_and_check(32'h3fb504f3, 32'h3fb504f3, `FP_RM_RMM, {FLAGS_NONE, 32'h3fffffff});
        apply_and_check(32'hbfb504f3, 32'h3fb504f3, `FP_RM_RDN, {FLAGS_NONE, 32'hc0000000});
        apply_and_check(32'hbfb504f3, 32'h3fb504f3, `FP_RM_RUP, {FLAGS_NONE, 32'hbfffffff});
        // 1.5 times (1 + 3 ulp) is an exact tie
        apply_and_check(32'h3fc00000, 32'h3f800003, `FP_RM_RNE, {FLAGS_NONE, 32'h3fc00004});
        apply_and_check(32'h3fc00000, 32'h3f800003, `FP_RM_RMM, {FLAGS_NONE, 32'h3fc00005});
        apply_and_check(32'h3fc00000, 32'h3f800003, `FP_RM_RTZ, {FLAGS_NONE, 32'h3fc00004});
        report_test("directed rounding", err_before);
    endtask

    task automatic run_random_modes();
        int          err_before;
        logic [2:0]  mode;
        logic [31:0] x;
        logic [31:0] y;
        err_before = errors;
        mode = `FP_RM_RNE;
        repeat (5) begin
            repeat (RANDOM_PAIRS) begin
                x = rand_normal();
                y = rand_normal();
                apply_and_check(x, y, mode, model_mul(x, y, mode));
            end
            mode = mode + 3'd1;
        end
        report_test("random rounding", err_before);
    endtask

    task automatic run_range();
        int err_before;
        err_before = errors;
        // 2^127 times 2 is beyond the largest exponent
        apply_and_check(32'h7f000000, 32'h40000000, `FP_RM_RTZ, {FLAGS_OVF, 32'h7f800000});
        apply_and_check(32'hff000000, 32'h40000000, `FP_RM_RNE, {FLAGS_OVF, 32'hff800000});
        // 2^-126 times 0.5 falls below the smallest normal
        apply_and_check(32'h00800000, 32'h3f000000, `FP_RM_RUP, {FLAGS_UDF, 32'h00000000});
        apply_and_check(32'h80800000, 32'h3f000000, `FP_RM_RNE, {FLAGS_UDF, 32'h80000000});
        report_test("range limits", err_before);
    endtask

    // Back-to-back starts, results collected in parallel
    task automatic run_pipeline();
        int          err_before;
        logic [31:0] x;
        logic [31:0] y;
        logic [2:0]  mode;
        logic        ok;
        err_before = errors;
        mode = `FP_RM_RNE;
        fork
            begin
                for (int i = 0; i < PIPE_OPS; i++) begin
                    x = rand_normal();
                    y = rand_normal();
                    @(posedge clk);
                    fp_x   <= x;
                    fp_y   <= y;
                    r_mode <= mode;
                    start  <= 1'b1;
                    expected_q.push_back(model_mul(x, y, mode));
                    mode = (mode == 3'd4) ? 3'd0 : mode + 3'd1;
                end
                @(posedge clk);
                start <= 1'b0;
            end
            begin
                for (int i = 0; i < PIPE_OPS; i++) begin
                    wait_done(ok);
                    if (!ok) begin
                        break;
                    end
                    compare_outputs(expected_q.pop_front());
                end
            end
        join
        expected_q.delete();
        report_test("pipelining", err_before);
    endtask

    initial begin
        rst_n  = 1'b0;
        start  = 1'b0;
        fp_x   = 32'h0;
        fp_y   = 32'h0;
        r_mode = 3'd0;
        checks = 0;
        errors = 0;
        check_reset();
        run_special();
        run_exact();
        run_rounding_directed();
        run_random_modes();
        run_range();
        run_pipeline();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* fp_mul.f */
+incdir+design
design/fp_mul_pkg.sv
design/fp_mul_decode.sv
design/fp_mul_booth.sv
design/fp_mul_execute.sv
design/fp_mul_result.sv
design/fp_mul_top.sv
sim/fp_mul_properties.sv
sim/fp_mul_tb.sv

/* Makefile */
VERILATOR  = verilator
VFLAGS     = --timing --assert
BUILDFLAGS = --binary -j 0
TOP        = fp_mul_tb
FILELIST   = fp_mul.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = TESTS FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(BUILDFLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
